/* source/am_pkg.sv */
package am_pkg;

	localparam int LEN_AM    = 48;
	localparam int N_ALIGNER = 20;

	typedef logic [LEN_AM-1:0]    am_value_t;   // M0 M1 M2 M4 M5 M6.
	typedef logic [4:0]           lane_id_t;
	typedef logic [N_ALIGNER-1:0] lane_mask_t;

	// Marker values per PCS lane, lane 0 first.
	localparam am_value_t AM_TABLE [N_ALIGNER] = '{
		48'hC168213E97DE,
		48'h9D718E628E71,
		48'h594BE8A6B417,
		48'h4D957BB26A84,
		48'hF507090AF8F6,
		48'hDD14C222EB3D,
		48'h9A4A2665B5D9,
		48'h7B456684BA99,
		48'hA024765FDB89,
		48'h68C9FB973604,
		48'hFD6C99029366,
		48'hB99155466EAA,
		48'h5CB9B2A3464D,
		48'h1AF8BDE50742,
		48'h83C7CA7C3835,
		48'h3536CDCAC932,
		48'hC4314C3BCEB3,
		48'hADD6B7522948,
		48'h5F662AA099D5,
		48'hC0F0E53F0F1A
	};

endpackage

/* source/pcs_block_pkg.sv */
package pcs_block_pkg;

	typedef logic [1:0]  sync_header_t;
	typedef logic [63:0] block_payload_t;  // Byte 0 in bits 63:56.

	localparam sync_header_t SH_DATA = 2'b01;
	localparam sync_header_t SH_CTRL = 2'b10;

	// One 66-bit block as delivered by the gearbox.
	typedef struct packed {
		sync_header_t   sync_header;
		block_payload_t payload;
	} pcs_block_t;

	// Compact record kept in the buffer, BIP bytes removed.
	typedef struct packed {
		logic              sh_valid;
		am_pkg::am_value_t am_value;
	} block_record_t;

endpackage

/* source/block_receiver.sv */
module block_receiver
(
	input  logic                         i_clock,
	input  logic                         i_arst_n,
	input  logic                         i_block_req,
	input  pcs_block_pkg::pcs_block_t    i_block,
	output logic                         o_block_ack,
	input  logic                         i_full,
	output logic                         o_push,
	output pcs_block_pkg::block_record_t o_record
);

	import pcs_block_pkg::*;

	logic accept;

	// New request seen and room in the buffer.
	assign accept = i_block_req && !o_block_ack && !i_full;

	always_ff @(posedge i_clock or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			o_block_ack <= 1'b0;
		end
		else if (accept)
		begin
			o_block_ack <= 1'b1;
		end
		else if (o_block_ack && !i_block_req)
		begin
			o_block_ack <= 1'b0;  // Return to idle.
		end
	end

	// One push per handshake, on the edge where ack rises.
	assign o_push = accept;

	assign o_record.sh_valid = (i_block.sync_header == SH_DATA) ||
		(i_block.sync_header == SH_CTRL);

	// Keep bytes 0, 1, 2 and 4, 5, 6.
	assign o_record.am_value = {i_block.payload[63:40], i_block.payload[31:8]};

endmodule

/* source/block_fifo.sv */
module block_fifo
#(
	parameter int FIFO_DEPTH = 4
)
(
	input  logic                         i_clock,
	input  logic                         i_arst_n,
	input  logic                         i_push,
	input  pcs_block_pkg::block_record_t i_record,
	output logic                         o_full,
	output logic                         o_valid,
	output pcs_block_pkg::block_record_t o_record,
	input  logic                         i_pop
);

	import pcs_block_pkg::*;

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	block_record_t    mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_push;
	logic             do_pop;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign o_full   = (count == CNT_W'(FIFO_DEPTH));
	assign o_valid  = (count != '0);
	assign o_record = mem[rd_ptr];  // Show-ahead head.

	assign do_push = i_push && !o_full;
	assign do_pop  = i_pop && o_valid;

	always_ff @(posedge i_clock)
	begin
		if (do_push)
			mem[wr_ptr] <= i_record;
	end

	always_ff @(posedge i_clock or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_pop)
				rd_ptr <= next_ptr(rd_ptr);
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

endmodule

/* source/am_lock_comparator.sv */
module am_lock_comparator
(
	input  logic               i_enable_mask,
	input  logic               i_timer_done,
	input  am_pkg::am_value_t  i_am_value,
	input  am_pkg::lane_mask_t i_match_mask,
	input  logic               i_sh_valid,
	output logic               o_am_match,
	output am_pkg::lane_mask_t o_match_vector
);

	import am_pkg::*;

	lane_mask_t match_vector;
	logic       any_match;
	logic       enable;

	// One comparator per lane, masked by the FSM.
	always_comb
	begin
		match_vector = '0;
		for (int i = 0; i < N_ALIGNER; i++)
		begin
			if (i_match_mask[i] && (AM_TABLE[i] == i_am_value))
				match_vector[i] = 1'b1;
		end
	end

	assign any_match = |match_vector;
	assign enable    = i_enable_mask || i_timer_done;  // Hunting or at expected slot.

	assign o_am_match     = any_match && enable && i_sh_valid;
	assign o_match_vector = match_vector;

endmodule

/* source/am_lock_fsm.sv */
module am_lock_fsm
#(
	parameter int AM_PERIOD = 16384,
	parameter int N_INVALID = 4
)
(
	input  logic                         i_clock,
	input  logic                         i_arst_n,
	input  logic                         i_valid,
	input  pcs_block_pkg::block_record_t i_record,
	output logic                         o_pop,
	output logic                         o_am_lock,
	output am_pkg::lane_id_t             o_lane_id
);

	import am_pkg::*;

	localparam int CNT_W = (AM_PERIOD > 1) ? $clog2(AM_PERIOD) : 1;
	localparam int INV_W = $clog2(N_INVALID + 1);

	typedef enum logic [1:0] {
		HUNT,
		CHECK_2ND,
		LOCKED
	} lock_state_t;

	lock_state_t      state;
	logic [CNT_W-1:0] block_cnt;   // Blocks since last marker slot.
	logic [INV_W-1:0] inv_cnt;
	lane_mask_t       lane_mask;   // One-hot, candidate or locked lane.
	lane_mask_t       cmp_mask;
	lane_mask_t       match_vector;
	lane_id_t         hit_lane;
	logic             timer_done;
	logic             enable_mask;
	logic             am_match;

	function automatic lane_id_t encode_lane(input lane_mask_t vec);
		lane_id_t id;
		id = '0;
		for (int i = N_ALIGNER - 1; i >= 0; i--)
		begin
			if (vec[i])
				id = lane_id_t'(i);
		end
		return id;
	endfunction

	assign o_pop       = i_valid;  // Never stalls.
	assign o_am_lock   = (state == LOCKED);
	assign timer_done  = i_valid && (block_cnt == CNT_W'(AM_PERIOD - 1));
	assign enable_mask = (state == HUNT);
	// All lanes stay visible until lock, so a wrong second marker can restart.
	assign cmp_mask    = (state == LOCKED) ? lane_mask : '1;
	assign hit_lane    = encode_lane(match_vector);

	am_lock_comparator u_comparator
	(
		.i_enable_mask  (enable_mask),
		.i_timer_done   (timer_done),
		.i_am_value     (i_record.am_value),
		.i_match_mask   (cmp_mask),
		.i_sh_valid     (i_record.sh_valid),
		.o_am_match     (am_match),
		.o_match_vector (match_vector)
	);

	always_ff @(posedge i_clock or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			state     <= HUNT;
			block_cnt <= '0;
			inv_cnt   <= '0;
			lane_mask <= '0;
			o_lane_id <= '0;
		end
		else if (i_valid)
		begin
			if (timer_done)
				block_cnt <= '0;
			else
				block_cnt <= block_cnt + 1'b1;

			case (state)
				HUNT:
				begin
					if (am_match)
					begin
						o_lane_id <= hit_lane;
						lane_mask <= lane_mask_t'(1) << hit_lane;
						block_cnt <= '0;  // Marker is slot zero.
						state     <= CHECK_2ND;
					end
				end
				CHECK_2ND:
				begin
					if (timer_done)
					begin
						if (am_match && |(match_vector & lane_mask))
						begin
							inv_cnt <= '0;
							state   <= LOCKED;
						end
						else if (am_match)
						begin
							// Other lane, take it as a new first marker.
							o_lane_id <= hit_lane;
							lane_mask <= lane_mask_t'(1) << hit_lane;
						end
						else
						begin
							state <= HUNT;
						end
					end
				end
				LOCKED:
				begin
					if (timer_done)
					begin
						if (am_match)
							inv_cnt <= '0;
						else if (inv_cnt == INV_W'(N_INVALID - 1))
						begin
							inv_cnt <= '0;
							state   <= HUNT;  // Lock lost.
						end
						else
							inv_cnt <= inv_cnt + 1'b1;
					end
				end
				default:
				begin
					state <= HUNT;
				end
			endcase
		end
	end

endmodule

/* source/am_lock_top.sv */
module am_lock_top
#(
	parameter int AM_PERIOD  = 16384,
	parameter int N_INVALID  = 4,
	parameter int FIFO_DEPTH = 4
)
(
	input  logic                      i_clock,
	input  logic                      i_arst_n,
	input  logic                      i_block_req,
	input  pcs_block_pkg::pcs_block_t i_block,
	output logic                      o_block_ack,
	output logic                      o_am_lock,
	output am_pkg::lane_id_t          o_lane_id
);

	import pcs_block_pkg::*;

	block_record_t push_record;
	block_record_t head_record;
	logic          push;
	logic          pop;
	logic          full;
	logic          valid;

	block_receiver u_receiver
	(
		.i_clock     (i_clock),
		.i_arst_n    (i_arst_n),
		.i_block_req (i_block_req),
		.i_block     (i_block),
		.o_block_ack (o_block_ack),
		.i_full      (full),
		.o_push      (push),
		.o_record    (push_record)
	);

	block_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_fifo
	(
		.i_clock  (i_clock),
		.i_arst_n (i_arst_n),
		.i_push   (push),
		.i_record (push_record),
		.o_full   (full),
		.o_valid  (valid),
		.o_record (head_record),
		.i_pop    (pop)
	);

	am_lock_fsm #(
		.AM_PERIOD (AM_PERIOD),
		.N_INVALID (N_INVALID)
	) u_lock_fsm
	(
		.i_clock   (i_clock),
		.i_arst_n  (i_arst_n),
		.i_valid   (valid),
		.i_record  (head_record),
		.o_pop     (pop),
		.o_am_lock (o_am_lock),
		.o_lane_id (o_lane_id)
	);

endmodule

/* verif/am_lock_tb.sv */
module am_lock_tb;

	import am_pkg::*;
	import pcs_block_pkg::*;

	localparam int AM_PERIOD = 8;
	localparam int TIMEOUT   = 20;

	typedef enum logic [1:0] {
		KIND_AM,
		KIND_DATA,
		KIND_BAD
	} block_kind_t;

	// One table row holds the block to send and the outputs expected after it.
	typedef struct packed {
		block_kind_t kind;
		lane_id_t    lane;
		logic        exp_lock;
		lane_id_t    exp_lane;
	} step_t;

	logic        clock;
	logic        arst_n;
	logic        req;
	pcs_block_t  blk_in;
	logic        ack;
	logic        am_lock;
	lane_id_t    lane_id;
	step_t       steps [$];
	int          errors;
	int          timeouts;
	int unsigned seed;

	am_lock_top #(
		.AM_PERIOD (AM_PERIOD)
	) DUT
	(
		.i_clock     (clock),
		.i_arst_n    (arst_n),
		.i_block_req (req),
		.i_block     (blk_in),
		.o_block_ack (ack),
		.o_am_lock   (am_lock),
		.o_lane_id   (lane_id)
	);

	initial
	begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// Marker slot followed by the data blocks of one period.
	task automatic add_period(input block_kind_t kind, input int lane, input logic exp_lock,
		input int exp_lane);
		step_t s;
		s.kind     = kind;
		s.lane     = lane_id_t'(lane);
		s.exp_lock = exp_lock;
		s.exp_lane = lane_id_t'(exp_lane);
		steps.push_back(s);
		for (int i = 1; i < AM_PERIOD; i++)
		begin
			s.kind = KIND_DATA;
			steps.push_back(s);
		end
	endtask

	function automatic pcs_block_t make_block(input step_t s, input int idx);
		pcs_block_t blk;
		am_value_t  am;
		logic [7:0] bip3;
		logic [7:0] bip7;
		am   = AM_TABLE[s.lane];
		bip3 = 8'($urandom);
		bip7 = 8'($urandom);
		blk.payload = {am[47:24], bip3, am[23:0], bip7};  // BIP in bytes 3 and 7.
		case (s.kind)
			KIND_AM:
				blk.sync_header = 2'b10;
			KIND_BAD:
				blk.sync_header = ((idx / AM_PERIOD) % 2 == 1) ? 2'b11 : 2'b00;
			default:
			begin
				blk.sync_header = 2'b01;
				blk.payload     = {32'($urandom), 32'($urandom)};
			end
		endcase
		return blk;
	endfunction

	// Polls at the falling edge, where ack is stable.
	task automatic wait_ack(input logic level, input string step_name);
		int cycles;
		cycles = 0;
		do
		begin
			@(negedge clock);
			cycles++;
		end
		while (ack !== level && cycles < TIMEOUT);
		if (ack !== level)
		begin
			timeouts++;
			$display("Timeout: ack did not %s within %0d cycles", step_name, TIMEOUT);
		end
	endtask

	task automatic check_outputs(input int idx, input logic exp_lock, input logic check_lane,
		input lane_id_t exp_lane);
		assert (am_lock === exp_lock)
		else
		begin
			errors++;
			$display("FAILED step %0d: o_am_lock = %h, expected %h", idx, am_lock, exp_lock);
		end
		if (check_lane)
		begin
			assert (lane_id === exp_lane)
			else
			begin
				errors++;
				$display("FAILED step %0d: o_lane_id = %h, expected %h", idx, lane_id, exp_lane);
			end
		end
	endtask

	initial
	begin
		step_t      s;
		pcs_block_t blk;
		errors   = 0;
		timeouts = 0;
		seed     = 74;
		void'($urandom(seed));
		arst_n   = 1'b0;
		req      = 1'b0;
		blk_in   = '0;

		add_period(KIND_BAD, 7, 1'b0, 0);   // Bad header must not start the hunt.
		add_period(KIND_AM, 7, 1'b0, 0);
		add_period(KIND_AM, 7, 1'b1, 7);
		add_period(KIND_AM, 7, 1'b1, 7);
		add_period(KIND_DATA, 0, 1'b1, 7);  // Missing marker.
		add_period(KIND_BAD, 7, 1'b1, 7);
		add_period(KIND_AM, 3, 1'b1, 7);    // Wrong lane.
		add_period(KIND_AM, 7, 1'b1, 7);    // Clears the miss count.
		add_period(KIND_DATA, 0, 1'b1, 7);
		add_period(KIND_BAD, 7, 1'b1, 7);
		add_period(KIND_AM, 3, 1'b1, 7);
		add_period(KIND_DATA, 0, 1'b0, 0);  // Fourth miss.
		add_period(KIND_AM, 3, 1'b0, 0);
		add_period(KIND_AM, 12, 1'b0, 0);
		add_period(KIND_AM, 12, 1'b1, 12);
		add_period(KIND_AM, 12, 1'b1, 12);

		repeat (4) @(posedge clock);
		arst_n <= 1'b1;
		@(negedge clock);
		assert (ack === 1'b0)
		else
		begin
			errors++;
			$display("FAILED after reset: o_block_ack = %h, expected 0", ack);
		end
		check_outputs(-1, 1'b0, 1'b1, '0);

		for (int i = 0; i < steps.size(); i++)
		begin
			s   = steps[i];
			blk = make_block(s, i);
			@(posedge clock);
			req    <= 1'b1;
			blk_in <= blk;
			wait_ack(1'b1, "rise");
			@(posedge clock);
			req <= 1'b0;
			wait_ack(1'b0, "fall");
			repeat (2) @(negedge clock);
			check_outputs(i, s.exp_lock, s.exp_lock, s.exp_lane);
		end

		$display("Checks done: %0d errors, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

/* all.f */
source/am_pkg.sv
source/pcs_block_pkg.sv
source/block_receiver.sv
source/block_fifo.sv
source/am_lock_comparator.sv
source/am_lock_fsm.sv
source/am_lock_top.sv
verif/am_lock_tb.sv

/* Bender.yml */
package:
  name: am_lock

sources:
  - source/am_pkg.sv
  - source/pcs_block_pkg.sv
  - source/block_receiver.sv
  - source/block_fifo.sv
  - source/am_lock_comparator.sv
  - source/am_lock_fsm.sv
  - source/am_lock_top.sv
  - target: test
    files:
      - verif/am_lock_tb.sv
